/* l2_mem_top.f */
hw/l2_geom_pkg.sv
hw/l2_bus_pkg.sv
hw/sram_cut.sv
hw/l2_req_split.sv
hw/l2_bank_column.sv
hw/l2_rsp_merge.sv
hw/l2_mem_top.sv
verif/l2_mem_tb.sv

/* Makefile */
# Verilator simulation of the L2 scratchpad

TOOL    ?= verilator
FLAGS   ?= --binary --timing -j 0
LINT    ?= --lint-only --timing -Wall
TOP     := l2_mem_tb
RTL_TOP := l2_mem_top
FLIST   := l2_mem_top.f

BUILD   := obj_dir
BIN     := $(BUILD)/V$(TOP)
LOG     := sim.log
SRCS    := $(shell cat $(FLIST))

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(FLIST) $(SRCS)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)

# the run passes only if the log holds the pass message
run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG)

lint:
	$(TOOL) $(LINT) --top-module $(RTL_TOP) \
		hw/l2_geom_pkg.sv hw/l2_bus_pkg.sv hw/sram_cut.sv hw/l2_req_split.sv \
		hw/l2_bank_column.sv hw/l2_rsp_merge.sv hw/l2_mem_top.sv

clean:
	rm -rf $(BUILD) $(LOG)

/* verif/l2_mem_tb.sv */
`default_nettype none

module l2_mem_tb;

  import l2_geom_pkg::*;
  import l2_bus_pkg::*;

  localparam int unsigned N_POOL         = 16;  // word addresses used by the random tests
  localparam int unsigned N_BYTE         = 24;
  localparam int unsigned N_ROW_READS    = 8;
  localparam int unsigned N_STREAM       = 48;
  localparam int unsigned TOTAL_REQS     = 2 * N_POOL + 2 * N_BYTE + 2 * N_PAR_CUTS
                                           + N_SER_CUTS + N_ROW_READS + 2 * N_STREAM;
  localparam int unsigned TIMEOUT_CYCLES = TOTAL_REQS + 200;
  localparam logic [31:0] LFSR_SEED      = 32'hcc0a_ffae;

  // what the port must return for one request
  typedef struct packed {
    logic              was_write;
    logic [BUS_DW-1:0] rdata;
    logic [31:0]       due;  // cycle count at which the response is visible
  } exp_rsp_t;

  logic        clk;
  logic        rst_n;
  bus_req_t    req;
  bus_rsp_t    rsp;
  logic [31:0] cycle_cnt;
  logic [31:0] lfsr_state;
  exp_rsp_t    mon_want;

  logic [BUS_DW-1:0] ref_mem [1024];  // one entry per bus word
  exp_rsp_t          exp_q [$];

  l2_mem_top UUT (
    .clk_i   (clk),
    .rst_n_i (rst_n),
    .req_i   (req),
    .rsp_o   (rsp)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stop_on_error(input string reason);
    $display("%s", reason);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_eq(input string name, input logic [127:0] got, input logic [127:0] want);
    if (got !== want) begin
      $display("[FAIL] %s: got 0x%h, expected 0x%h", name, got, want);
      stop_on_error("value mismatch on the response port");
    end
  endtask

  // galois step, right shift, output bit is the old lsb
  function automatic logic lfsr_bit();
    logic b;
    b          = lfsr_state[0];
    lfsr_state = {1'b0, lfsr_state[31:1]} ^ (b ? 32'ha300_0000 : 32'h0);
    return b;
  endfunction

  function automatic logic [127:0] rand_bits(input int n);
    logic [127:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r[i] = lfsr_bit();
    end
    return r;
  endfunction

  // spread over all four rows, distinct word index per entry
  function automatic logic [9:0] pool_addr(input int i);
    return {2'(i), 8'(i * 29 + 3)};
  endfunction

  // drive one request and queue the response the model predicts
  task automatic issue_req(input logic we, input logic [9:0] waddr,
                           input logic [BUS_DW-1:0] wdata, input logic [BUS_STRB_W-1:0] strb);
    exp_rsp_t want;
    @(posedge clk);
    #2;
    req.valid = 1'b1;
    req.we    = we;
    req.addr  = {waddr, 4'h0};
    req.wdata = wdata;
    req.strb  = strb;
    if (we) begin
      for (int b = 0; b < BUS_STRB_W; b++) begin
        if (strb[b]) ref_mem[waddr][8*b +: 8] = wdata[8*b +: 8];
      end
      want.rdata = '0;
    end else begin
      want.rdata = ref_mem[waddr];  // sees every earlier write
    end
    want.was_write = we;
    want.due       = cycle_cnt + 3;
    exp_q.push_back(want);
  endtask

  task automatic write_word(input logic [9:0] waddr, input logic [BUS_DW-1:0] wdata,
                            input logic [BUS_STRB_W-1:0] strb);
    issue_req(1'b1, waddr, wdata, strb);
  endtask

  task automatic read_word(input logic [9:0] waddr);
    issue_req(1'b0, waddr, '0, '0);
  endtask

  task automatic go_idle();
    @(posedge clk);
    #2;
    req = '0;
  endtask

  task automatic wait_drained();
    while (exp_q.size() != 0) @(posedge clk);
  endtask

  task automatic check_reset_state();
    repeat (5) begin
      @(negedge clk);
      check_eq("rsp_o.valid", 128'(rsp.valid), 128'h0);
    end
  endtask

  task automatic full_word_test();
    $display("full word write and read back");
    for (int i = 0; i < N_POOL; i++) begin
      write_word(pool_addr(i), rand_bits(BUS_DW), '1);
    end
    for (int i = 0; i < N_POOL; i++) begin
      read_word(pool_addr(i));
    end
    go_idle();
    wait_drained();
  endtask

  task automatic byte_strobe_test();
    logic [9:0]            a;
    logic [BUS_STRB_W-1:0] strb;
    $display("byte strobes");
    for (int n = 0; n < N_BYTE; n++) begin
      a = pool_addr(int'(rand_bits(4)));
      write_word(a, rand_bits(BUS_DW), 16'(rand_bits(BUS_STRB_W)));
      read_word(a);
    end
    // one column gets no bytes at all
    for (int c = 0; c < N_PAR_CUTS; c++) begin
      a    = pool_addr(c + 5);
      strb = 16'(rand_bits(BUS_STRB_W)) & ~(16'hf << (4 * c));
      write_word(a, rand_bits(BUS_DW), strb);
      read_word(a);
    end
    go_idle();
    wait_drained();
  endtask

  task automatic row_select_test();
    logic [7:0] idx;
    idx = 8'h5a;
    $display("row selection");
    for (int r = 0; r < N_SER_CUTS; r++) begin
      write_word({2'(r), idx}, rand_bits(BUS_DW), '1);
    end
    // consecutive reads never hit the same row
    for (int k = 0; k < N_ROW_READS; k++) begin
      read_word({2'((k * 3 + 1) % 4), idx});
    end
    go_idle();
    wait_drained();
  endtask

  task automatic stream_test();
    logic [9:0] a;
    $display("pipelined traffic");
    for (int n = 0; n < N_STREAM; n++) begin
      a = pool_addr(int'(rand_bits(4)));
      if (lfsr_bit()) begin
        write_word(a, rand_bits(BUS_DW), 16'(rand_bits(BUS_STRB_W)));
        read_word(a);  // right behind the write
      end else begin
        read_word(a);
      end
    end
    go_idle();
    wait_drained();
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      stop_on_error("timeout: the tests did not finish within the cycle limit");
    end
  end

  // responses are stable in the middle of the cycle
  always @(negedge clk) begin
    if (rsp.valid) begin
      if (exp_q.size() == 0) begin
        stop_on_error("a response arrived with no request outstanding");
      end else begin
        mon_want = exp_q.pop_front();
        check_eq("rsp_o.valid cycle", 128'(cycle_cnt), 128'(mon_want.due));
        check_eq("rsp_o.was_write", 128'(rsp.was_write), 128'(mon_want.was_write));
        check_eq("rsp_o.rdata", rsp.rdata, mon_want.rdata);
      end
    end else if (exp_q.size() != 0 && exp_q[0].due <= cycle_cnt) begin
      stop_on_error("a response did not arrive three cycles after its request");
    end
  end

  initial begin
    cycle_cnt  = '0;
    lfsr_state = LFSR_SEED;
    req        = '0;
    rst_n      = 1'b0;
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;

    check_reset_state();
    full_word_test();
    byte_strobe_test();
    row_select_test();
    stream_test();

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* hw/l2_mem_top.sv */
`default_nettype none

// banked l2 scratchpad, three-cycle pipelined word port
module l2_mem_top (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  l2_bus_pkg::bus_req_t req_i,
  output l2_bus_pkg::bus_rsp_t rsp_o
);

  import l2_geom_pkg::*;
  import l2_bus_pkg::*;

  bank_req_t [N_PAR_CUTS-1:0] bank_req;
  cut_data_t [N_PAR_CUTS-1:0] col_rdata;
  logic                       rd_tag;
  logic                       wr_tag;

  // stage 1, register and split the request
  l2_req_split i_req_split (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .req_i      (req_i),
    .bank_req_o (bank_req),
    .rd_tag_o   (rd_tag),
    .wr_tag_o   (wr_tag)
  );

  // stage 2, cut access in every column
  for (genvar c = 0; c < N_PAR_CUTS; c++) begin : gen_cols
    l2_bank_column i_col (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .bank_req_i (bank_req[c]),
      .rdata_o    (col_rdata[c])
    );
  end

  // stage 3
  l2_rsp_merge i_rsp_merge (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .rd_tag_i    (rd_tag),
    .wr_tag_i    (wr_tag),
    .col_rdata_i (col_rdata),
    .rsp_o       (rsp_o)
  );

endmodule

`default_nettype wire

/* hw/l2_rsp_merge.sv */
`default_nettype none

module l2_rsp_merge (
  input  logic                                                 clk_i,
  input  logic                                                 rst_n_i,
  input  logic                                                 rd_tag_i,
  input  logic                                                 wr_tag_i,
  input  l2_geom_pkg::cut_data_t [l2_geom_pkg::N_PAR_CUTS-1:0] col_rdata_i,
  output l2_bus_pkg::bus_rsp_t                                 rsp_o
);

  import l2_geom_pkg::*;

  logic              rd_tag_q, wr_tag_q;
  logic [BUS_DW-1:0] rdata_d;
  logic              valid_q, was_write_q;
  logic [BUS_DW-1:0] rdata_q;

  // column 0 lands in the low bits
  always_comb begin
    for (int c = 0; c < N_PAR_CUTS; c++) begin
      rdata_d[c*CUT_DW +: CUT_DW] = col_rdata_i[c];
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_tag_q    <= 1'b0;
      wr_tag_q    <= 1'b0;
      valid_q     <= 1'b0;
      was_write_q <= 1'b0;
    end else begin
      rd_tag_q    <= rd_tag_i;  // now lined up with the cut read data
      wr_tag_q    <= wr_tag_i;
      valid_q     <= rd_tag_q || wr_tag_q;
      was_write_q <= wr_tag_q;
    end
  end

  // writes and idle cycles return zero data
  always_ff @(posedge clk_i) begin
    rdata_q <= rd_tag_q ? rdata_d : '0;
  end

  assign rsp_o = '{valid: valid_q, was_write: was_write_q, rdata: rdata_q};

endmodule

`default_nettype wire

/* hw/l2_bank_column.sv */
`default_nettype none

// one 32-bit column, N_SER_CUTS cuts deep
module l2_bank_column (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  l2_bus_pkg::bank_req_t  bank_req_i,
  output l2_geom_pkg::cut_data_t rdata_o
);

  import l2_geom_pkg::*;

  cut_addr_t                  cut_addr_d, cut_addr_q;
  row_idx_t                   row_idx_d, row_idx_q;
  logic      [N_SER_CUTS-1:0] cut_req;
  cut_data_t [N_SER_CUTS-1:0] cut_rdata;

  // an idle column keeps presenting the last accessed address
  assign cut_addr_d = bank_req_i.req ? bank_req_i.addr[WORD_IDX_W-1:0] : cut_addr_q;
  assign row_idx_d  = bank_req_i.req ? bank_req_i.addr[WORD_IDX_W +: ROW_IDX_W] : row_idx_q;

  // one-hot row decode
  always_comb begin
    cut_req            = '0;
    cut_req[row_idx_d] = bank_req_i.req;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cut_addr_q <= '0;
      row_idx_q  <= '0;
    end else begin
      cut_addr_q <= cut_addr_d;
      row_idx_q  <= row_idx_d;  // remembers which cut holds the read data
    end
  end

  for (genvar r = 0; r < N_SER_CUTS; r++) begin : gen_rows
    sram_cut i_cut (
      .clk_i   (clk_i),
      .req_i   (cut_req[r]),
      .we_i    (bank_req_i.we),
      .addr_i  (cut_addr_d),
      .wdata_i (bank_req_i.wdata),
      .be_i    (bank_req_i.be),
      .rdata_o (cut_rdata[r])
    );
  end

  // select with the row of the access, not of the current request
  assign rdata_o = cut_rdata[row_idx_q];

endmodule

`default_nettype wire

/* hw/l2_req_split.sv */
`default_nettype none

module l2_req_split (
  input  logic                                                clk_i,
  input  logic                                                rst_n_i,
  input  l2_bus_pkg::bus_req_t                                req_i,
  output l2_bus_pkg::bank_req_t [l2_geom_pkg::N_PAR_CUTS-1:0] bank_req_o,
  output logic                                                rd_tag_o,
  output logic                                                wr_tag_o
);

  import l2_geom_pkg::*;

  logic                  valid_q;
  logic                  we_q;
  bank_addr_t            word_addr_q;
  logic [BUS_DW-1:0]     wdata_q;
  logic [BUS_STRB_W-1:0] strb_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= req_i.valid;
    end
  end

  // payload only moves with a valid request
  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      we_q        <= req_i.we;
      word_addr_q <= req_i.addr[LINE_OFF_W +: BANK_AW];  // columns are word addressed
      wdata_q     <= req_i.wdata;
      strb_q      <= req_i.strb;
    end
  end

  always_comb begin
    cut_strb_t col_be;
    for (int c = 0; c < N_PAR_CUTS; c++) begin
      col_be                = strb_q[c*CUT_BE_W +: CUT_BE_W];
      bank_req_o[c].we      = we_q;
      bank_req_o[c].addr    = word_addr_q;
      bank_req_o[c].wdata   = wdata_q[c*CUT_DW +: CUT_DW];
      bank_req_o[c].be      = col_be;
      // a write with no bytes for this column leaves it idle
      bank_req_o[c].req     = valid_q && (!we_q || (|col_be));
    end
  end

  // the tags ride along to the merge stage and become the response
  assign rd_tag_o = valid_q && !we_q;
  assign wr_tag_o = valid_q && we_q;

endmodule

`default_nettype wire

/* hw/sram_cut.sv */
`default_nettype none

// behavioral stand-in for one single-port sram macro
module sram_cut (
  input  logic                   clk_i,
  input  logic                   req_i,
  input  logic                   we_i,
  input  l2_geom_pkg::cut_addr_t addr_i,
  input  l2_geom_pkg::cut_data_t wdata_i,
  input  l2_geom_pkg::cut_strb_t be_i,
  output l2_geom_pkg::cut_data_t rdata_o
);

  import l2_geom_pkg::*;

  cut_data_t mem_q [CUT_N_WORDS];

  // byte-wise write, enabled bytes only
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int b = 0; b < CUT_BE_W; b++) begin
        if (be_i[b]) begin
          mem_q[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // read port has one cycle of latency
  // output holds its last value when the cut is not accessed
  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule

`default_nettype wire

/* hw/l2_bus_pkg.sv */
`default_nettype none

package l2_bus_pkg;

  import l2_geom_pkg::*;

  // external port request, one bus word per request
  typedef struct packed {
    logic                  valid;  // one-cycle strobe
    logic                  we;
    logic [ADDR_W-1:0]     addr;   // byte address, low LINE_OFF_W bits ignored
    logic [BUS_DW-1:0]     wdata;
    logic [BUS_STRB_W-1:0] strb;
  } bus_req_t;

  // external port response, one per request
  typedef struct packed {
    logic              valid;
    logic              was_write;
    logic [BUS_DW-1:0] rdata;  // zero for writes
  } bus_rsp_t;

  // request to one column of cuts
  typedef struct packed {
    logic       req;
    logic       we;
    bank_addr_t addr;  // word addressed
    cut_data_t  wdata;
    cut_strb_t  be;
  } bank_req_t;

endpackage

`default_nettype wire

/* hw/l2_geom_pkg.sv */
`default_nettype none

package l2_geom_pkg;

  // one sram cut, must match the behavioral model
  localparam int unsigned CUT_DW      = 32;          // bits per cut word
  localparam int unsigned CUT_N_WORDS = 256;
  localparam int unsigned CUT_BE_W    = CUT_DW / 8;  // byte enables per cut word

  // the array of cuts
  localparam int unsigned N_PAR_CUTS = 4;  // columns, side by side on the bus word
  localparam int unsigned N_SER_CUTS = 4;  // cuts stacked in one column
  localparam int unsigned BUS_DW     = N_PAR_CUTS * CUT_DW;
  localparam int unsigned BUS_STRB_W = BUS_DW / 8;

  // byte address, low to high: line offset, word index, row index
  localparam int unsigned LINE_OFF_W = $clog2(BUS_STRB_W);   // 4, requests are word aligned
  localparam int unsigned WORD_IDX_W = $clog2(CUT_N_WORDS);  // 8
  localparam int unsigned ROW_IDX_W  = $clog2(N_SER_CUTS);   // 2
  localparam int unsigned BANK_AW    = WORD_IDX_W + ROW_IDX_W;
  localparam int unsigned ADDR_W     = LINE_OFF_W + BANK_AW;

  // word index inside one cut, shared by all cuts of a column
  typedef logic [WORD_IDX_W-1:0] cut_addr_t;

  // picks one cut out of a column
  typedef logic [ROW_IDX_W-1:0] row_idx_t;

  // row and word index together, as seen by a column
  typedef logic [BANK_AW-1:0] bank_addr_t;

  typedef logic [CUT_DW-1:0]   cut_data_t;
  typedef logic [CUT_BE_W-1:0] cut_strb_t;

endpackage

`default_nettype wire
